// ==== common/mmio_axi_pkg.sv ====
// MMIO lite bus definitions
// Channel payload structs and widths shared by the 64-bit read/write port
// and the 512-bit write-only port
`default_nettype none

package mmio_axi_pkg;

    // Bus field widths
    localparam int ADDR_W = 16;
    localparam int ID_W = 4;
    localparam int USER_W = 2;
    localparam int RESP_W = 2;

    // Data widths in bytes for the two ports
    localparam int NARROW_BYTES = 8;
    localparam int WIDE_BYTES = 64;
    localparam int WIDE_LANES = WIDE_BYTES / NARROW_BYTES;

    // Response code for a normal completion
    localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [ID_W-1:0] id_t;
    typedef logic [USER_W-1:0] user_t;
    typedef logic [NARROW_BYTES*8-1:0] data64_t;

    // Write address channel
    typedef struct packed {
        addr_t addr;
        id_t   id;
        user_t user;
    } aw_t;

    // Read address channel, same layout as the write address
    typedef struct packed {
        addr_t addr;
        id_t   id;
        user_t user;
    } ar_t;

    // Narrow write data channel
    typedef struct packed {
        data64_t                 data;
        logic [NARROW_BYTES-1:0] strb;
    } w64_t;

    // The wide write word arrives flat and is read back one 64-bit lane at a time
    typedef union packed {
        logic [WIDE_BYTES*8-1:0]       flat;
        data64_t [WIDE_LANES-1:0]      lane;
    } wide_data_u;

    // Wide write data channel
    typedef struct packed {
        wide_data_u            data;
        logic [WIDE_BYTES-1:0] strb;
    } w512_t;

    // Write response channel
    typedef struct packed {
        id_t               id;
        user_t             user;
        logic [RESP_W-1:0] resp;
    } b_t;

    // Read data channel
    typedef struct packed {
        id_t               id;
        user_t             user;
        logic [RESP_W-1:0] resp;
        data64_t           data;
    } r_t;

endpackage

`default_nettype wire

// ==== common/mmio_csr_pkg.sv ====
// MMIO register map
// Register indexes, block identifier and status constants for the read port
`default_nettype none

package mmio_csr_pkg;

    // Registers are 64 bits wide, so the index starts at byte address bit 3
    localparam int CSR_IDX_W = 12;
    localparam int CSR_IDX_LSB = 3;

    typedef logic [CSR_IDX_W-1:0] csr_idx_t;

    // ==============================
    // Register indexes
    // ==============================

    // Feature header group, decoded from the low four index bits
    localparam csr_idx_t CSR_DFH = 12'h000;
    localparam csr_idx_t CSR_ID_L = 12'h001;
    localparam csr_idx_t CSR_ID_H = 12'h002;
    localparam csr_idx_t CSR_ADDR_ECHO = 12'h007;

    localparam csr_idx_t CSR_STATUS = 12'h010;

    // Last 64-bit write
    localparam csr_idx_t CSR_WR64_DATA = 12'h020;
    localparam csr_idx_t CSR_WR64_ADDR = 12'h030;
    localparam csr_idx_t CSR_WR64_STRB = 12'h031;

    // Last 512-bit write, data spread over eight lanes starting at lane 0
    localparam csr_idx_t CSR_WR512_LANE0 = 12'h040;
    localparam csr_idx_t CSR_WR512_ADDR = 12'h050;
    localparam csr_idx_t CSR_WR512_STRB = 12'h051;

    // ==============================
    // Constants
    // ==============================

    localparam logic [127:0] BLOCK_ID = 128'h9e4d_27b1_5c08_4f3a_b6e2_0d71_a5c9_3f86;

    // Clock frequency reported in status bits 31 to 16
    localparam logic [15:0] CLK_FREQ_MHZ = 16'd250;

    // Interface type in status bits 3 to 0, 1 means the lite bus
    localparam logic [3:0] STATUS_IF_TYPE = 4'h1;

    // Single entry feature list: feature type in the top nibble, end of list at bit 40
    localparam logic [3:0] DFH_FEATURE_TYPE = 4'h1;
    localparam int DFH_EOL_BIT = 40;
    localparam logic [63:0] DFH_VALUE = {DFH_FEATURE_TYPE, 60'h0} | (64'h1 << DFH_EOL_BIT);

endpackage

`default_nettype wire

// ==== dv/mmio_tb_checks.svh ====
// MMIO test block testbench helpers
// Random bit source, lite bus driver tasks and typed compare tasks,
// included into the testbench module body
`ifndef MMIO_TB_CHECKS_SVH
`define MMIO_TB_CHECKS_SVH

// ==============================
// Random bits and failure exit
// ==============================

// Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit handed out
function automatic logic [63:0] take_bits(input int n);
    logic [63:0] val;
    logic        fb;
    int          i;
    val = '0;
    for (i = 0; i < n; i++)
    begin
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        val = {val[62:0], fb};
    end
    return val;
endfunction

task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1);
endtask

// ==============================
// Compare tasks
// ==============================

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
        $display("error at %0t: %s expected %b actual %b", $time, name, exp, act);
        stop_with_failure();
    end
endtask

task automatic check_b(input string name, input b_t exp, input b_t act);
    if (act !== exp)
    begin
        $display("error at %0t: %s expected %h actual %h", $time, name, exp, act);
        stop_with_failure();
    end
endtask

task automatic check_r(input string name, input r_t exp, input r_t act);
    if (act !== exp)
    begin
        $display("error at %0t: %s expected %h actual %h", $time, name, exp, act);
        stop_with_failure();
    end
endtask

// ==============================
// Bus drivers
// ==============================

// One write on either port. Called and returning on a falling edge.
// Address and data start after their own random delays, and bready is
// randomly held low once back-pressure is switched on
task automatic write_port(input logic wide, input aw_t a, input w512_t w);
    int   aw_delay;
    int   w_delay;
    logic aw_acc;
    logic w_acc;
    logic b_done;
    logic b_rdy;
    b_t   exp_b;
    aw_delay = int'(take_bits(2));
    w_delay = int'(take_bits(3)) % 5;
    aw_acc = 1'b0;
    w_acc = 1'b0;
    b_done = 1'b0;
    exp_b.id = a.id;
    exp_b.user = a.user;
    exp_b.resp = 2'b00;
    fork
        begin
            repeat (aw_delay) @(negedge clk);
            // Payload goes to both ports, only the selected one sees valid
            mmio64_aw = a;
            mmio512_aw = a;
            mmio64_awvalid = !wide;
            mmio512_awvalid = wide;
            while (!(wide ? mmio512_awready : mmio64_awready))
                @(negedge clk);
            @(negedge clk);
            mmio64_awvalid = 1'b0;
            mmio512_awvalid = 1'b0;
            aw_acc = 1'b1;
        end
        begin
            repeat (w_delay) @(negedge clk);
            mmio64_w.data = w.data.flat[63:0];
            mmio64_w.strb = w.strb[7:0];
            mmio512_w = w;
            mmio64_wvalid = !wide;
            mmio512_wvalid = wide;
            while (!(wide ? mmio512_wready : mmio64_wready))
                @(negedge clk);
            @(negedge clk);
            mmio64_wvalid = 1'b0;
            mmio512_wvalid = 1'b0;
            w_acc = 1'b1;
        end
        begin
            while (!b_done)
            begin
                b_rdy = bp_en ? (take_bits(2) != 0) : 1'b1;
                mmio64_bready = b_rdy;
                mmio512_bready = b_rdy;
                // bvalid follows bready within the cycle, so look just after the edge
                #1;
                if (aw_acc && w_acc && b_rdy)
                begin
                    check_flag(wide ? "mmio512_bvalid" : "mmio64_bvalid", 1'b1,
                               wide ? mmio512_bvalid : mmio64_bvalid);
                    check_b(wide ? "mmio512_b" : "mmio64_b", exp_b,
                            wide ? mmio512_b : mmio64_b);
                    b_done = 1'b1;
                end
                else
                begin
                    // No response before both halves are in, and a stalled
                    // response keeps both channels closed
                    check_flag(wide ? "mmio512_bvalid" : "mmio64_bvalid", 1'b0,
                               wide ? mmio512_bvalid : mmio64_bvalid);
                    if (aw_acc)
                        check_flag(wide ? "mmio512_awready" : "mmio64_awready", 1'b0,
                                   wide ? mmio512_awready : mmio64_awready);
                    if (w_acc)
                        check_flag(wide ? "mmio512_wready" : "mmio64_wready", 1'b0,
                                   wide ? mmio512_wready : mmio64_wready);
                end
                @(negedge clk);
            end
        end
    join
endtask

// One read on the 64-bit port, checking the three-cycle latency,
// the held response under rready back-pressure and the single request slot
task automatic read_reg(input ar_t a, input data64_t exp_data);
    r_t   exp_r;
    int   n;
    logic done;
    logic rdy;
    exp_r.id = a.id;
    exp_r.user = a.user;
    exp_r.resp = 2'b00;
    exp_r.data = exp_data;
    mmio64_ar = a;
    mmio64_arvalid = 1'b1;
    while (!mmio64_arready)
        @(negedge clk);
    @(negedge clk);
    mmio64_arvalid = 1'b0;
    n = 1;
    done = 1'b0;
    while (!done)
    begin
        // Outputs are sampled before rready changes on this edge
        check_flag("mmio64_arready", 1'b0, mmio64_arready);
        check_flag("mmio64_rvalid", n >= 3, mmio64_rvalid);
        if (mmio64_rvalid)
            check_r("mmio64_r", exp_r, mmio64_r);
        rdy = bp_en ? (take_bits(2) != 0) : 1'b1;
        mmio64_rready = rdy;
        if (mmio64_rvalid && rdy)
            done = 1'b1;
        @(negedge clk);
        n++;
    end
    check_flag("mmio64_rvalid", 1'b0, mmio64_rvalid);
endtask

`endif

// ==== dv/mmio_tb.sv ====
// MMIO test block testbench
// Random writes on both ports and reads over the whole register map,
// checked against a model of the last write on each port
`timescale 1ns/10ps
`default_nettype none

module mmio_tb;

    import mmio_axi_pkg::*;
    import mmio_csr_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam logic [31:0] LFSR_SEED = 32'h5d6f13f6;

    // Rounds of one 64-bit and one 512-bit write, each followed by 13 readbacks
    localparam int N_ROUNDS = 12;
    localparam int N_ECHO = 8;
    localparam int N_RANDOM_READS = 24;
    localparam int N_OPS = 4 + 21 + N_ROUNDS * 28 + N_ECHO + N_RANDOM_READS;

    logic  clk;
    logic  reset_n;
    aw_t   mmio64_aw;
    logic  mmio64_awvalid;
    logic  mmio64_awready;
    w64_t  mmio64_w;
    logic  mmio64_wvalid;
    logic  mmio64_wready;
    b_t    mmio64_b;
    logic  mmio64_bvalid;
    logic  mmio64_bready;
    ar_t   mmio64_ar;
    logic  mmio64_arvalid;
    logic  mmio64_arready;
    r_t    mmio64_r;
    logic  mmio64_rvalid;
    logic  mmio64_rready;
    aw_t   mmio512_aw;
    logic  mmio512_awvalid;
    logic  mmio512_awready;
    w512_t mmio512_w;
    logic  mmio512_wvalid;
    logic  mmio512_wready;
    b_t    mmio512_b;
    logic  mmio512_bvalid;
    logic  mmio512_bready;

    // Model of the last accepted write on each port
    addr_t        m64_addr;
    data64_t      m64_data;
    logic [7:0]   m64_strb;
    addr_t        m512_addr;
    logic [511:0] m512_data;
    logic [63:0]  m512_strb;

    logic [31:0] lfsr_state;
    logic        bp_en;

    mmio_test_top u_dut (.*);

    `include "mmio_tb_checks.svh"

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #((N_OPS * 40 + 10) * CLK_PERIOD);
        $display("Timeout: the run did not finish in the expected time");
        stop_with_failure();
    end

    // Expected read word, built from the register map rules
    function automatic data64_t expected_read(input addr_t addr);
        csr_idx_t idx;
        data64_t  val;
        idx = addr[14:3];
        val = '0;
        case (idx)
            CSR_DFH:
            begin
                val[63:60] = DFH_FEATURE_TYPE;
                val[DFH_EOL_BIT] = 1'b1;
            end
            CSR_ID_L:       val = BLOCK_ID[63:0];
            CSR_ID_H:       val = BLOCK_ID[127:64];
            CSR_ADDR_ECHO:  val = {16'h0, addr, 16'h0, addr};
            CSR_STATUS:
            begin
                val[31:16] = CLK_FREQ_MHZ;
                val[3:0] = STATUS_IF_TYPE;
            end
            CSR_WR64_DATA:  val = m64_data;
            CSR_WR64_ADDR:  val = {48'h0, m64_addr};
            CSR_WR64_STRB:  val = {56'h0, m64_strb};
            CSR_WR512_ADDR: val = {48'h0, m512_addr};
            CSR_WR512_STRB: val = m512_strb;
            default:
            begin
                // Eight lanes of the wide word, lane 0 holds the low bits
                if (idx[11:3] == CSR_WR512_LANE0[11:3])
                    val = m512_data[idx[2:0] * 64 +: 64];
            end
        endcase
        return val;
    endfunction

    // Read one index at a random byte address, id and user
    task automatic read_index(input csr_idx_t idx);
        ar_t a;
        a.addr = 16'(take_bits(16));
        a.addr[14:3] = idx;
        a.id = 4'(take_bits(4));
        a.user = 2'(take_bits(2));
        read_reg(a, expected_read(a.addr));
    endtask

    // Every captured register of both ports
    task automatic check_captures();
        int k;
        read_index(CSR_WR64_DATA);
        read_index(CSR_WR64_ADDR);
        read_index(CSR_WR64_STRB);
        for (k = 0; k < 8; k++)
            read_index(CSR_WR512_LANE0 + 12'(k));
        read_index(CSR_WR512_ADDR);
        read_index(CSR_WR512_STRB);
    endtask

    task automatic random_write(input logic wide);
        aw_t   a;
        w512_t w;
        int    k;
        a.addr = 16'(take_bits(16));
        a.id = 4'(take_bits(4));
        a.user = 2'(take_bits(2));
        w = '0;
        if (wide)
        begin
            for (k = 0; k < 8; k++)
                w.data.flat[k * 64 +: 64] = take_bits(64);
            w.strb[31:0] = 32'(take_bits(32));
            w.strb[63:32] = 32'(take_bits(32));
        end
        else
        begin
            w.data.flat[63:0] = take_bits(64);
            w.strb[7:0] = 8'(take_bits(8));
        end
        write_port(wide, a, w);
        if (wide)
        begin
            m512_addr = a.addr;
            m512_data = w.data.flat;
            m512_strb = w.strb;
        end
        else
        begin
            m64_addr = a.addr;
            m64_data = w.data.flat[63:0];
            m64_strb = w.strb[7:0];
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial
    begin
        lfsr_state = LFSR_SEED;
        bp_en = 1'b0;
        m64_addr = '0;
        m64_data = '0;
        m64_strb = '0;
        m512_addr = '0;
        m512_data = '0;
        m512_strb = '0;
        reset_n = 1'b0;
        mmio64_aw = '0;
        mmio64_awvalid = 1'b0;
        mmio64_w = '0;
        mmio64_wvalid = 1'b0;
        mmio64_bready = 1'b1;
        mmio64_ar = '0;
        mmio64_arvalid = 1'b0;
        mmio64_rready = 1'b1;
        mmio512_aw = '0;
        mmio512_awvalid = 1'b0;
        mmio512_w = '0;
        mmio512_wvalid = 1'b0;
        mmio512_bready = 1'b1;
        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        // Idle handshake state out of reset
        check_flag("mmio64_awready", 1'b1, mmio64_awready);
        check_flag("mmio64_wready", 1'b1, mmio64_wready);
        check_flag("mmio64_arready", 1'b1, mmio64_arready);
        check_flag("mmio512_awready", 1'b1, mmio512_awready);
        check_flag("mmio512_wready", 1'b1, mmio512_wready);
        check_flag("mmio64_bvalid", 1'b0, mmio64_bvalid);
        check_flag("mmio512_bvalid", 1'b0, mmio512_bvalid);
        check_flag("mmio64_rvalid", 1'b0, mmio64_rvalid);

        // Constant registers with rready held high
        read_index(CSR_DFH);
        read_index(CSR_ID_L);
        read_index(CSR_ID_H);
        read_index(CSR_STATUS);

        // Capture registers are still zero, as are holes in the map
        check_captures();
        read_index(12'h003);
        read_index(12'h008);
        read_index(12'h00f);
        read_index(12'h011);
        read_index(12'h032);
        read_index(12'h048);
        read_index(12'h052);
        read_index(12'hfff);

        // Interleaved writes on both ports under random back-pressure
        bp_en = 1'b1;
        for (int i = 0; i < N_ROUNDS; i++)
        begin
            random_write(1'b0);
            check_captures();
            random_write(1'b1);
            check_captures();
        end

        for (int i = 0; i < N_ECHO; i++)
            read_index(CSR_ADDR_ECHO);

        // Anywhere in the populated part of the map
        for (int i = 0; i < N_RANDOM_READS; i++)
            read_index(12'(take_bits(7)));

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/mmio_csr_read.sv ====
// Register read decode
// Two-stage decode of the held read index into the 64-bit read data,
// drawing on constants and the captured write state of both ports
`timescale 1ns/10ps
`default_nettype none

module mmio_csr_read
(
    input  logic                     clk,
    input  mmio_axi_pkg::ar_t        held_ar,
    input  logic                     stage1_en,
    input  logic                     stage2_en,
    input  mmio_axi_pkg::aw_t        wr64_aw,
    input  mmio_axi_pkg::data64_t    wr64_data,
    input  logic [7:0]               wr64_strb,
    input  mmio_axi_pkg::aw_t        wr512_aw,
    input  mmio_axi_pkg::wide_data_u wr512_data,
    input  logic [63:0]              wr512_strb,
    output mmio_axi_pkg::r_t         r
);

    import mmio_axi_pkg::*;
    import mmio_csr_pkg::*;

    csr_idx_t rd_idx;
    csr_idx_t rd_idx_q;
    data64_t  low_group_q;
    data64_t  lane_q;
    data64_t  status_word;
    data64_t  rd_data;

    // Byte address to 64-bit register index
    assign rd_idx = held_ar.addr[CSR_IDX_LSB +: $bits(csr_idx_t)];

    // Status word with the clock frequency and the bus type, the rest reserved
    assign status_word = {32'h0, CLK_FREQ_MHZ, 12'h0, STATUS_IF_TYPE};

    // ==============================
    // Stage one
    // ==============================

    // Narrow the feature header group and the wide data down to one word each
    always_ff @(posedge clk)
    begin
        if (stage1_en)
        begin
            rd_idx_q <= rd_idx;
            lane_q <= wr512_data.lane[rd_idx[2:0]];

            case (rd_idx[3:0])
                CSR_DFH[3:0]:       low_group_q <= DFH_VALUE;
                CSR_ID_L[3:0]:      low_group_q <= BLOCK_ID[63:0];
                CSR_ID_H[3:0]:      low_group_q <= BLOCK_ID[127:64];
                // Full byte address in both halves, readable as either 32-bit word
                CSR_ADDR_ECHO[3:0]: low_group_q <= {2{32'(held_ar.addr)}};
                default:            low_group_q <= '0;
            endcase
        end
    end

    // ==============================
    // Stage two
    // ==============================

    // Select among the reduced groups and the direct registers
    always_comb
    begin
        rd_data = '0;
        if (rd_idx_q[11:4] == CSR_DFH[11:4])
            rd_data = low_group_q;
        else if (rd_idx_q[11:3] == CSR_WR512_LANE0[11:3])
            rd_data = lane_q;
        else
        begin
            case (rd_idx_q)
                CSR_STATUS:     rd_data = status_word;
                CSR_WR64_DATA:  rd_data = wr64_data;
                CSR_WR64_ADDR:  rd_data = 64'(wr64_aw.addr);
                CSR_WR64_STRB:  rd_data = 64'(wr64_strb);
                CSR_WR512_ADDR: rd_data = 64'(wr512_aw.addr);
                CSR_WR512_STRB: rd_data = wr512_strb;
                default:        rd_data = '0;
            endcase
        end
    end

    // Response payload, held while the read waits on rready
    always_ff @(posedge clk)
    begin
        if (stage2_en)
        begin
            r.id <= held_ar.id;
            r.user <= held_ar.user;
            r.resp <= RESP_OKAY;
            r.data <= rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mmio_rd_ctrl.sv ====
// Read request control for the 64-bit port
// Holds one read, steps the two decode stages and drives the response handshake
`timescale 1ns/10ps
`default_nettype none

module mmio_rd_ctrl
(
    input  logic              clk,
    input  logic              reset_n,
    input  mmio_axi_pkg::ar_t ar,
    input  logic              arvalid,
    output logic              arready,
    output logic              rvalid,
    input  logic              rready,
    output mmio_axi_pkg::ar_t held_ar,
    output logic              stage1_en,
    output logic              stage2_en
);

    logic       ar_held;
    logic [1:0] rd_pipe;
    logic       rd_retire;

    // Only one read in flight, new requests wait until the response is taken
    assign arready = !ar_held;

    // Bit 0 marks stage one done, bit 1 marks stage two done and the data valid
    assign rvalid = rd_pipe[1];
    assign rd_retire = rvalid && rready;

    // Each stage captures exactly once per request so r stays stable
    // while the response waits on rready
    assign stage1_en = ar_held && !rd_pipe[0];
    assign stage2_en = rd_pipe[0] && !rd_pipe[1];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            ar_held <= 1'b0;
            rd_pipe <= 2'b00;
        end
        else if (rd_retire)
        begin
            ar_held <= 1'b0;
            rd_pipe <= 2'b00;
        end
        else
        begin
            if (arvalid && arready)
                ar_held <= 1'b1;
            rd_pipe <= {rd_pipe[0], ar_held};
        end
    end

    // Request payload, captured at the address handshake
    always_ff @(posedge clk)
    begin
        if (arvalid && arready)
            held_ar <= ar;
    end

endmodule

`default_nettype wire

// ==== hw/mmio_test_top.sv ====
// MMIO register test block
// A 64-bit read/write port and a 512-bit write-only port, each capturing
// its last write, with a register map read back over the 64-bit port
`timescale 1ns/10ps
`default_nettype none

module mmio_test_top
(
    input  logic                clk,
    input  logic                reset_n,

    // 64-bit read/write port
    input  mmio_axi_pkg::aw_t   mmio64_aw,
    input  logic                mmio64_awvalid,
    output logic                mmio64_awready,
    input  mmio_axi_pkg::w64_t  mmio64_w,
    input  logic                mmio64_wvalid,
    output logic                mmio64_wready,
    output mmio_axi_pkg::b_t    mmio64_b,
    output logic                mmio64_bvalid,
    input  logic                mmio64_bready,
    input  mmio_axi_pkg::ar_t   mmio64_ar,
    input  logic                mmio64_arvalid,
    output logic                mmio64_arready,
    output mmio_axi_pkg::r_t    mmio64_r,
    output logic                mmio64_rvalid,
    input  logic                mmio64_rready,

    // 512-bit write-only port
    input  mmio_axi_pkg::aw_t   mmio512_aw,
    input  logic                mmio512_awvalid,
    output logic                mmio512_awready,
    input  mmio_axi_pkg::w512_t mmio512_w,
    input  logic                mmio512_wvalid,
    output logic                mmio512_wready,
    output mmio_axi_pkg::b_t    mmio512_b,
    output logic                mmio512_bvalid,
    input  logic                mmio512_bready
);

    import mmio_axi_pkg::*;

    // Captured write state of both ports, read by the register decode
    aw_t        wr64_aw;
    data64_t    wr64_data;
    logic [7:0] wr64_strb;
    aw_t        wr512_aw;
    wide_data_u wr512_data;
    logic [63:0] wr512_strb;

    // Read control to decode
    ar_t  held_ar;
    logic stage1_en;
    logic stage2_en;

    mmio_wr_capture #(.DATA_BYTES(NARROW_BYTES)) u_wr64 (
        .clk(clk), .reset_n(reset_n),
        .aw_in(mmio64_aw), .awvalid(mmio64_awvalid), .awready(mmio64_awready),
        .wdata(mmio64_w.data), .wstrb(mmio64_w.strb),
        .wvalid(mmio64_wvalid), .wready(mmio64_wready),
        .b(mmio64_b), .bvalid(mmio64_bvalid), .bready(mmio64_bready),
        .cap_aw(wr64_aw), .cap_wdata(wr64_data), .cap_wstrb(wr64_strb)
    );

    // Wide data enters flat and comes back out as the lane view
    mmio_wr_capture #(.DATA_BYTES(WIDE_BYTES)) u_wr512 (
        .clk(clk), .reset_n(reset_n),
        .aw_in(mmio512_aw), .awvalid(mmio512_awvalid), .awready(mmio512_awready),
        .wdata(mmio512_w.data.flat), .wstrb(mmio512_w.strb),
        .wvalid(mmio512_wvalid), .wready(mmio512_wready),
        .b(mmio512_b), .bvalid(mmio512_bvalid), .bready(mmio512_bready),
        .cap_aw(wr512_aw), .cap_wdata(wr512_data), .cap_wstrb(wr512_strb)
    );

    mmio_rd_ctrl u_rd_ctrl (
        .clk(clk), .reset_n(reset_n),
        .ar(mmio64_ar), .arvalid(mmio64_arvalid), .arready(mmio64_arready),
        .rvalid(mmio64_rvalid), .rready(mmio64_rready),
        .held_ar(held_ar), .stage1_en(stage1_en), .stage2_en(stage2_en)
    );

    mmio_csr_read u_csr_read (
        .clk(clk), .held_ar(held_ar),
        .stage1_en(stage1_en), .stage2_en(stage2_en),
        .wr64_aw(wr64_aw), .wr64_data(wr64_data), .wr64_strb(wr64_strb),
        .wr512_aw(wr512_aw), .wr512_data(wr512_data), .wr512_strb(wr512_strb),
        .r(mmio64_r)
    );

endmodule

`default_nettype wire

// ==== hw/mmio_wr_capture.sv ====
// Write capture for one lite port
// Takes address and data independently, returns the write response once
// both are held, and keeps the last write visible to the register decode
`timescale 1ns/10ps
`default_nettype none

module mmio_wr_capture
#(
    parameter int DATA_BYTES = 8
)
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  mmio_axi_pkg::aw_t       aw_in,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [DATA_BYTES*8-1:0] wdata,
    input  logic [DATA_BYTES-1:0]   wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output mmio_axi_pkg::b_t        b,
    output logic                    bvalid,
    input  logic                    bready,
    output mmio_axi_pkg::aw_t       cap_aw,
    output logic [DATA_BYTES*8-1:0] cap_wdata,
    output logic [DATA_BYTES-1:0]   cap_wstrb
);

    import mmio_axi_pkg::*;

    logic aw_held;
    logic w_held;
    logic wr_done;

    // Each channel stalls while its own item is waiting for the response
    assign awready = !aw_held;
    assign wready = !w_held;

    // The response goes out in the same cycle that it is taken
    assign wr_done = aw_held && w_held && bready;
    assign bvalid = wr_done;

    // Response echoes the held request, always a normal completion
    assign b = '{id: cap_aw.id, user: cap_aw.user, resp: RESP_OKAY};

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            aw_held <= 1'b0;
            w_held <= 1'b0;
        end
        else if (wr_done)
        begin
            // Both ready signals rise again in the next cycle
            aw_held <= 1'b0;
            w_held <= 1'b0;
        end
        else
        begin
            if (awvalid && awready)
                aw_held <= 1'b1;
            if (wvalid && wready)
                w_held <= 1'b1;
        end
    end

    // The held request doubles as the readback copy of the last write,
    // so it stays put after completion until the next accepted write
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            cap_aw <= '0;
            cap_wdata <= '0;
            cap_wstrb <= '0;
        end
        else
        begin
            if (awvalid && awready)
                cap_aw <= aw_in;
            if (wvalid && wready)
            begin
                cap_wdata <= wdata;
                cap_wstrb <= wstrb;
            end
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+dv
common/mmio_axi_pkg.sv
common/mmio_csr_pkg.sv
hw/mmio_wr_capture.sv
hw/mmio_rd_ctrl.sv
hw/mmio_csr_read.sv
hw/mmio_test_top.sv
dv/mmio_tb.sv
